// ==== branch_frontend.f ====
verilog/bp_pkg.sv
verilog/pc_select.sv
verilog/branch_history_table.sv
verilog/stage_pipe.sv
verilog/branch_resolver.sv
verilog/branch_frontend.sv
sim/tb_branch_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the branch front end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f branch_frontend.f \
	--top-module tb_branch_frontend \
	-Mdir "$OBJ" -o tb_branch_frontend
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/tb_branch_frontend" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim/tb_branch_frontend.sv ====
`timescale 1ns/1ps

module tb_branch_frontend;

	localparam int WAYS    = 4;
	localparam int SETS    = 16;
	localparam int CLK_NS  = 4;
	localparam int RST_CYC = 8;

	// cycles each test runs after its reset
	localparam int SEQ_CYC   = 20;
	localparam int FIRST_CYC = 12;
	localparam int LOOP_CYC  = 80;
	localparam int JUMP_CYC  = 18;
	localparam int KIND_CYC  = 10;
	localparam int EVICT_CYC = 24;
	// eleven resets in total, six of them in the branch kind test
	localparam int BUDGET = 11 * RST_CYC + SEQ_CYC + FIRST_CYC + LOOP_CYC + JUMP_CYC
		+ 6 * KIND_CYC + EVICT_CYC;
	localparam int WATCHDOG_NS = (BUDGET * 2 + 100) * CLK_NS;

	localparam bp_pkg::btype_t BEQ = 6'b100000;
	localparam bp_pkg::btype_t BNE = 6'b010000;

	logic                 CLK;
	logic                 nrst;
	bp_pkg::decode_info_t id_info;
	bp_pkg::exe_flags_t   exe_flags;
	bp_pkg::pc_t          fetch_pc;
	logic                 fetch_taken;
	bp_pkg::redirect_t    redirect;

	branch_frontend #(
		.WAYS (WAYS),
		.SETS (SETS)
	) uut (
		.CLK         (CLK),
		.nrst        (nrst),
		.id_info     (id_info),
		.exe_flags   (exe_flags),
		.fetch_pc    (fetch_pc),
		.fetch_taken (fetch_taken),
		.redirect    (redirect)
	);

	//////////////////////////////////////////////////
	// reference model state
	//////////////////////////////////////////////////

	logic         m_valid [SETS][WAYS];
	bp_pkg::tag_t m_tag   [SETS][WAYS];
	bp_pkg::pc_t  m_tgt   [SETS][WAYS];
	bp_pkg::ctr_t m_ctr   [SETS][WAYS];
	int           m_fifo  [SETS];
	bp_pkg::pc_t    m_pc;
	bp_pkg::stage_t m_id;
	bp_pkg::stage_t m_exe;

	// program map, indexed by word address
	bp_pkg::btype_t prog_btype [1024];
	logic           prog_jump  [1024];
	bp_pkg::pc_t    prog_tgt   [1024];
	logic           prog_z     [1024];
	logic           prog_less  [1024];
	// per-visit z values for one branch, default afterwards
	logic           z_seq [$];
	bp_pkg::pc_t    seq_pc;

	// event counts of the running test
	int n_redirect;
	int n_taken;
	int n_discard;
	int first_taken_pc;
	int last_redir_pc;

	int errors       = 0;
	int base_errors  = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int seed         = 32'h8087_4d37;

	initial begin
		CLK = 1'b0;
		forever #(CLK_NS / 2) CLK = ~CLK;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_pc(input bp_pkg::pc_t got, input bp_pkg::pc_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_taken(input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: fetch_taken is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_redirect(input bp_pkg::redirect_t got, input bp_pkg::redirect_t exp);
		// pc only matters while the redirect is valid
		if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
			errors++;
			$display("mismatch at %0t: redirect is %b/%0d, expected %b/%0d",
				$time, got.valid, got.pc, exp.valid, exp.pc);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// model helpers
	//////////////////////////////////////////////////

	function automatic logic [WAYS-1:0] model_hits(input bp_pkg::pc_t pc);
		logic [WAYS-1:0] h;
		for (int w = 0; w < WAYS; w++) begin
			h[w] = m_valid[pc[3:0]][w] && (m_tag[pc[3:0]][w] == pc[9:4]);
		end
		return h;
	endfunction

	// -1 when the address is not in the table
	function automatic int find_way(input bp_pkg::pc_t pc);
		logic [WAYS-1:0] h;
		int w;
		h = model_hits(pc);
		w = -1;
		for (int i = 0; i < WAYS; i++) begin
			if (h[i]) begin
				w = i;
			end
		end
		return w;
	endfunction

	// taken rule per one-hot kind, from the top bit down
	function automatic logic rule_taken(input bp_pkg::exe_flags_t ef);
		case (ef.btype)
			6'b100000: return ef.z;
			6'b010000: return !ef.z;
			6'b001000, 6'b000010: return ef.less;
			6'b000100, 6'b000001: return !ef.less;
			default: return 1'b0;
		endcase
	endfunction

	task automatic expect_ctr(input bp_pkg::pc_t pc, input bp_pkg::ctr_t exp);
		int w;
		w = find_way(pc);
		if (w < 0) begin
			errors++;
			$display("%0t: pc %0d is missing from the predictor model", $time, pc);
		end else if (m_ctr[pc[3:0]][w] != exp) begin
			errors++;
			$display("mismatch at %0t: counter of pc %0d is %b, expected %b",
				$time, pc, m_ctr[pc[3:0]][w], exp);
		end
	endtask

	task automatic set_branch(input bp_pkg::pc_t pc, input bp_pkg::btype_t bt,
		input bp_pkg::pc_t tgt, input logic z, input logic less);
		prog_btype[pc] = bt;
		prog_tgt[pc]   = tgt;
		prog_z[pc]     = z;
		prog_less[pc]  = less;
	endtask

	task automatic clear_program();
		for (int i = 0; i < 1024; i++) begin
			prog_btype[i] = '0;
			prog_jump[i]  = 1'b0;
			prog_tgt[i]   = '0;
			prog_z[i]     = 1'b0;
			prog_less[i]  = 1'b0;
		end
		z_seq.delete();
		seq_pc = '1;
	endtask

	task automatic reset_dut();
		nrst      = 1'b0;
		id_info   = '0;
		exe_flags = '0;
		repeat (RST_CYC) @(posedge CLK);
		#1;
		nrst = 1'b1;
		for (int s = 0; s < SETS; s++) begin
			m_fifo[s] = 0;
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
			end
		end
		m_pc           = '0;
		m_id           = '0;
		m_exe          = '0;
		n_redirect     = 0;
		n_taken        = 0;
		n_discard      = 0;
		first_taken_pc = -1;
		last_redir_pc  = -1;
	endtask

	//////////////////////////////////////////////////
	// one clock cycle, entered 1 ns after the edge
	//////////////////////////////////////////////////

	task automatic step();
		bp_pkg::decode_info_t di;
		bp_pkg::exe_flags_t   ef;
		bp_pkg::redirect_t    rd;
		bp_pkg::stage_t       nid;
		bp_pkg::stage_t       nexe;
		logic [WAYS-1:0]      fh;
		logic [WAYS-1:0]      dh;
		logic [WAYS-1:0]      eh;
		logic                 p_taken;
		logic                 tk;
		bp_pkg::pc_t          p_tgt;
		bp_pkg::set_t         s;
		int                   w;

		// environment answers for the decode and execute slots
		di = '0;
		ef = '0;
		if (m_id.valid) begin
			di.is_jump  = prog_jump[m_id.pc];
			di.is_btype = (prog_btype[m_id.pc] != '0);
			di.target   = prog_tgt[m_id.pc];
		end
		if (m_exe.valid) begin
			ef.btype = prog_btype[m_exe.pc];
			ef.less  = prog_less[m_exe.pc];
			ef.z     = prog_z[m_exe.pc];
			if (m_exe.pc == seq_pc && z_seq.size() > 0) begin
				ef.z = z_seq.pop_front();
			end
		end
		id_info   = di;
		exe_flags = ef;

		// taken only on a single hit with counter msb set
		fh      = model_hits(m_pc);
		s       = m_pc[3:0];
		w       = find_way(m_pc);
		p_taken = 1'b0;
		p_tgt   = '0;
		if ($onehot(fh)) begin
			p_taken = m_ctr[s][w][1];
			p_tgt   = m_tgt[s][w];
		end

		tk       = rule_taken(ef);
		rd.valid = m_exe.valid && (ef.btype != '0) && (tk != m_exe.pred_taken);
		rd.pc    = tk ? m_exe.target : m_exe.pc + bp_pkg::pc_t'(1);

		// outputs settled well before the next edge
		#2;
		check_pc(fetch_pc, m_pc, "fetch_pc");
		check_taken(fetch_taken, p_taken);
		check_redirect(redirect, rd);

		if (p_taken) begin
			n_taken++;
			if (first_taken_pc < 0) begin
				first_taken_pc = int'(m_pc);
			end
		end
		if (rd.valid) begin
			n_redirect++;
			last_redir_pc = int'(rd.pc);
			// current fetch plus a live decode slot are dropped
			n_discard += 1 + int'(m_id.valid);
		end

		// table write, allocation wins over the counter update
		dh = model_hits(m_id.pc);
		eh = model_hits(m_exe.pc);
		if (m_id.valid && (di.is_jump || di.is_btype) && dh == '0) begin
			s             = m_id.pc[3:0];
			w             = m_fifo[s];
			m_valid[s][w] = 1'b1;
			m_tag[s][w]   = m_id.pc[9:4];
			m_tgt[s][w]   = di.target;
			m_ctr[s][w]   = di.is_jump ? bp_pkg::CTR_JUMP_INIT : bp_pkg::CTR_BRANCH_INIT;
			m_fifo[s]     = (w + 1) % WAYS;
		end else if (m_exe.valid && ef.btype != '0 && $onehot(eh)) begin
			s = m_exe.pc[3:0];
			w = find_way(m_exe.pc);
			if (tk && m_ctr[s][w] != 2'b11) begin
				m_ctr[s][w] = m_ctr[s][w] + 2'b01;
			end else if (!tk && m_ctr[s][w] != 2'b00) begin
				m_ctr[s][w] = m_ctr[s][w] - 2'b01;
			end
		end

		// advance the slots, a redirect empties both
		nexe.valid      = m_id.valid && !rd.valid;
		nexe.pc         = m_id.pc;
		nexe.pred_taken = m_id.pred_taken;
		nexe.target     = m_id.pred_taken ? m_id.target : di.target;
		nid.valid       = !rd.valid;
		nid.pc          = m_pc;
		nid.pred_taken  = p_taken;
		nid.target      = p_tgt;
		m_exe           = nexe;
		m_id            = nid;
		if (rd.valid) begin
			m_pc = rd.pc;
		end else if (p_taken) begin
			m_pc = p_tgt;
		end else begin
			m_pc = m_pc + bp_pkg::pc_t'(1);
		end

		@(posedge CLK);
		#1;
	endtask

	task automatic run(input int cycles);
		repeat (cycles) step();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == base_errors) begin
			$display("test %-20s ok", name);
		end else begin
			tests_failed++;
			$display("test %-20s failed with %0d errors", name, errors - base_errors);
		end
		base_errors = errors;
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_sequential();
		reset_dut();
		clear_program();
		run(SEQ_CYC);
		check_count(n_redirect, 0, "redirect count");
		check_count(n_taken, 0, "taken count");
		check_pc(fetch_pc, bp_pkg::pc_t'(SEQ_CYC), "final fetch_pc");
		finish_test("sequential fetch");
	endtask

	// beq at 5 to 20, fetch 6 and 7 are lost, 20 follows
	task automatic test_first_taken();
		reset_dut();
		clear_program();
		set_branch(10'd5, BEQ, 10'd20, 1'b1, 1'b0);
		run(FIRST_CYC);
		check_count(n_redirect, 1, "redirect count");
		check_count(last_redir_pc, 20, "redirect pc");
		check_count(n_discard, 2, "discarded fetches");
		check_count(n_taken, 0, "taken count");
		check_pc(fetch_pc, 10'd24, "final fetch_pc");
		// allocated at 01 and stepped once by the taken outcome
		expect_ctr(10'd5, 2'b10);
		finish_test("first taken branch");
	endtask

	// bne at 8 loops to 2, beq at 12 returns to 0
	task automatic test_loop();
		reset_dut();
		clear_program();
		set_branch(10'd8, BNE, 10'd2, 1'b1, 1'b0);
		set_branch(10'd12, BEQ, 10'd0, 1'b1, 1'b0);
		seq_pc = 10'd8;
		// two taken visits, then four not taken
		z_seq = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};
		run(LOOP_CYC);
		check_count(first_taken_pc, 8, "first predicted-taken pc");
		check_count(n_redirect, 4, "redirect count");
		expect_ctr(10'd8, 2'b00);
		expect_ctr(10'd12, 2'b11);
		finish_test("loop branch");
	endtask

	// jump at 3 to 10, beq at 6 brings fetch back to 0
	task automatic test_jump();
		reset_dut();
		clear_program();
		prog_jump[3] = 1'b1;
		prog_tgt[3]  = 10'd10;
		set_branch(10'd6, BEQ, 10'd0, 1'b1, 1'b0);
		run(JUMP_CYC);
		check_count(n_redirect, 1, "redirect count");
		check_count(n_taken, 1, "taken count");
		check_count(first_taken_pc, 3, "first predicted-taken pc");
		check_pc(fetch_pc, 10'd15, "final fetch_pc");
		expect_ctr(10'd3, 2'b11);
		finish_test("jump");
	endtask

	task automatic test_kinds();
		bp_pkg::btype_t     bt;
		bp_pkg::exe_flags_t ef;
		int                 rnd;
		logic               exp_taken;
		for (int k = 0; k < 6; k++) begin
			reset_dut();
			clear_program();
			rnd = $random(seed);
			bt  = bp_pkg::btype_t'(6'b100000 >> k);
			set_branch(10'd4, bt, 10'd30, rnd[0], rnd[1]);
			run(KIND_CYC);
			ef.z      = rnd[0];
			ef.less   = rnd[1];
			ef.btype  = bt;
			exp_taken = rule_taken(ef);
			// a first visit is predicted not taken
			// taken resolves in cycle 6, then fetch runs 30, 31 and 32
			check_pc(fetch_pc, exp_taken ? 10'd33 : bp_pkg::pc_t'(KIND_CYC),
				"final fetch_pc");
			check_count(n_taken, 0, "taken count");
		end
		finish_test("six branch kinds");
	endtask

	// five taken branches in set 3 chained 3, 19, 35, 51, 67 and back to 3
	// on the second pass the jump at 4 skips 19, so 35, 51 and 67 are fetched again
	task automatic test_set_eviction();
		bp_pkg::pc_t pc;
		reset_dut();
		clear_program();
		for (int i = 0; i < 5; i++) begin
			pc = bp_pkg::pc_t'(3 + 16 * i);
			set_branch(pc, BEQ, (i == 4) ? 10'd3 : pc + 10'd16, 1'b1, 1'b0);
		end
		// learned on the wrong path behind the first redirect
		// its allocation also drops the counter step of pc 3
		prog_jump[4] = 1'b1;
		prog_tgt[4]  = 10'd35;
		// pc 3 is taken on its first visit and falls through on its second
		seq_pc = 10'd3;
		z_seq  = '{1'b1, 1'b0};
		run(EVICT_CYC);
		check_count(n_redirect, 5, "redirect count");
		check_count(n_taken, 4, "taken count");
		check_count(first_taken_pc, 4, "first predicted-taken pc");
		check_pc(fetch_pc, 10'd4, "final fetch_pc");
		// 67 took way 0, then 3 came back into way 1
		check_count(find_way(10'd67), 0, "way of pc 67");
		check_count(find_way(10'd3), 1, "way of pc 3");
		check_count(find_way(10'd35), 2, "way of pc 35");
		check_count(find_way(10'd51), 3, "way of pc 51");
		check_count(find_way(10'd19), -1, "way of pc 19");
		expect_ctr(10'd3, 2'b00);
		expect_ctr(10'd35, 2'b11);
		expect_ctr(10'd51, 2'b11);
		expect_ctr(10'd67, 2'b10);
		finish_test("set eviction");
	endtask

	initial begin
		nrst      = 1'b0;
		id_info   = '0;
		exe_flags = '0;
		test_sequential();
		test_first_taken();
		test_loop();
		test_jump();
		test_kinds();
		test_set_eviction();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog/bp_pkg.sv ====
package bp_pkg;

	// address split is {tag, set}
	localparam int PC_W    = 10;
	localparam int TAG_W   = 6;
	localparam int SET_W   = 4;
	localparam int CTR_W   = 2;
	localparam int BTYPE_W = 6;

	typedef logic [PC_W-1:0]    pc_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [SET_W-1:0]   set_t;
	typedef logic [CTR_W-1:0]   ctr_t;
	typedef logic [BTYPE_W-1:0] btype_t;

	// one-hot branch kind bit positions
	localparam int BT_BEQ  = 5;
	localparam int BT_BNE  = 4;
	localparam int BT_BLT  = 3;
	localparam int BT_BGE  = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	// weakly not taken for branches, strongly taken for jumps
	localparam ctr_t CTR_BRANCH_INIT = 2'b01;
	localparam ctr_t CTR_JUMP_INIT   = 2'b11;

	////////////////////////////////////////////////
	// stage payloads
	////////////////////////////////////////////////

	typedef struct packed {
		logic is_jump;
		logic is_btype;
		pc_t  target;
	} decode_info_t;

	typedef struct packed {
		logic   z;
		logic   less;
		btype_t btype;
	} exe_flags_t;

	typedef struct packed {
		logic valid;
		pc_t  pc;
		logic pred_taken;
		pc_t  target;
	} stage_t;

	typedef struct packed {
		logic valid;
		pc_t  pc;
	} redirect_t;

	// resolved outcome sent back to the table
	typedef struct packed {
		logic valid;
		logic taken;
	} update_t;

endpackage

// ==== verilog/branch_frontend.sv ====
`timescale 1ns/1ps

module branch_frontend #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                 CLK,
	input  logic                 nrst,
	input  bp_pkg::decode_info_t id_info,
	input  bp_pkg::exe_flags_t   exe_flags,
	output bp_pkg::pc_t          fetch_pc,
	output logic                 fetch_taken,
	output bp_pkg::redirect_t    redirect
);

	bp_pkg::pc_t     fetch_target;
	bp_pkg::stage_t  id_stage;
	bp_pkg::stage_t  exe_stage;
	bp_pkg::update_t exe_update;

	// fetch address generation
	pc_select u_pc_select (
		.CLK         (CLK),
		.nrst        (nrst),
		.redirect    (redirect),
		.pred_taken  (fetch_taken),
		.pred_target (fetch_target),
		.fetch_pc    (fetch_pc)
	);

	// prediction table, searched at fetch, decode and execute
	branch_history_table #(
		.WAYS (WAYS),
		.SETS (SETS)
	) u_bht (
		.CLK          (CLK),
		.nrst         (nrst),
		.fetch_pc     (fetch_pc),
		.fetch_taken  (fetch_taken),
		.fetch_target (fetch_target),
		.id_pc        (id_stage.pc),
		.id_valid     (id_stage.valid),
		.id_info      (id_info),
		.exe_pc       (exe_stage.pc),
		.exe_update   (exe_update)
	);

	// redirect flushes both younger slots
	stage_pipe u_stage_pipe (
		.CLK          (CLK),
		.nrst         (nrst),
		.fetch_pc     (fetch_pc),
		.fetch_taken  (fetch_taken),
		.fetch_target (fetch_target),
		.flush        (redirect.valid),
		.id_target    (id_info.target),
		.id_stage     (id_stage),
		.exe_stage    (exe_stage)
	);

	branch_resolver u_resolver (
		.exe_stage  (exe_stage),
		.exe_flags  (exe_flags),
		.redirect   (redirect),
		.exe_update (exe_update)
	);

endmodule

// ==== verilog/branch_history_table.sv ====
`timescale 1ns/1ps

module branch_history_table #(
	parameter int WAYS = 4,
	parameter int SETS = 16
) (
	input  logic                 CLK,
	input  logic                 nrst,
	input  bp_pkg::pc_t          fetch_pc,
	output logic                 fetch_taken,
	output bp_pkg::pc_t          fetch_target,
	input  bp_pkg::pc_t          id_pc,
	input  logic                 id_valid,
	input  bp_pkg::decode_info_t id_info,
	input  bp_pkg::pc_t          exe_pc,
	input  bp_pkg::update_t      exe_update
);

	localparam int SET_BITS = $clog2(SETS);
	localparam int TAG_BITS = bp_pkg::PC_W - SET_BITS;
	localparam int WAY_BITS = $clog2(WAYS);

	// table storage, indexed [set][way]
	logic                valid_q [SETS][WAYS];
	logic [TAG_BITS-1:0] tag_q   [SETS][WAYS];
	bp_pkg::pc_t         tgt_q   [SETS][WAYS];
	bp_pkg::ctr_t        ctr_q   [SETS][WAYS];
	// per set fifo replacement pointer
	logic [WAY_BITS-1:0] fifo_q  [SETS];

	// tag compare across all ways of one set
	function automatic logic [WAYS-1:0] match_ways(
		input logic [SET_BITS-1:0] s,
		input logic [TAG_BITS-1:0] t
	);
		logic [WAYS-1:0] m;
		for (int w = 0; w < WAYS; w++) begin
			m[w] = valid_q[s][w] && (tag_q[s][w] == t);
		end
		return m;
	endfunction

	// encode the hit vector, zero when nothing hits
	function automatic logic [WAY_BITS-1:0] way_index(input logic [WAYS-1:0] hit);
		logic [WAY_BITS-1:0] idx;
		idx = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (hit[w]) begin
				idx = WAY_BITS'(w);
			end
		end
		return idx;
	endfunction

	function automatic logic single_hit(input logic [WAYS-1:0] hit);
		return (hit != '0) && ((hit & (hit - 1'b1)) == '0);
	endfunction

	////////////////////////////////////////////////
	// fetch lookup
	////////////////////////////////////////////////

	logic [SET_BITS-1:0] f_set;
	logic [TAG_BITS-1:0] f_tag;
	logic [WAYS-1:0]     f_hit;
	logic [WAY_BITS-1:0] f_way;

	assign f_set = fetch_pc[SET_BITS-1:0];
	assign f_tag = fetch_pc[bp_pkg::PC_W-1:SET_BITS];
	assign f_hit = match_ways(f_set, f_tag);
	assign f_way = way_index(f_hit);

	// counter msb is the direction
	assign fetch_taken  = single_hit(f_hit) && ctr_q[f_set][f_way][1];
	assign fetch_target = tgt_q[f_set][f_way];

	////////////////////////////////////////////////
	// decode allocation
	////////////////////////////////////////////////

	logic [SET_BITS-1:0] d_set;
	logic [TAG_BITS-1:0] d_tag;
	logic [WAYS-1:0]     d_hit;
	logic [WAY_BITS-1:0] d_way;
	logic                alloc;
	bp_pkg::ctr_t        alloc_ctr;

	assign d_set = id_pc[SET_BITS-1:0];
	assign d_tag = id_pc[bp_pkg::PC_W-1:SET_BITS];
	assign d_hit = match_ways(d_set, d_tag);
	// victim is whatever the fifo pointer names
	assign d_way = fifo_q[d_set];

	// only branches and jumps not yet in the table
	assign alloc     = id_valid && (id_info.is_jump || id_info.is_btype) && (d_hit == '0);
	assign alloc_ctr = id_info.is_jump ? bp_pkg::CTR_JUMP_INIT : bp_pkg::CTR_BRANCH_INIT;

	////////////////////////////////////////////////
	// execute counter update
	////////////////////////////////////////////////

	logic [SET_BITS-1:0] e_set;
	logic [TAG_BITS-1:0] e_tag;
	logic [WAYS-1:0]     e_hit;
	logic [WAY_BITS-1:0] e_way;
	logic                upd;
	bp_pkg::ctr_t        e_ctr;
	bp_pkg::ctr_t        e_next;

	assign e_set = exe_pc[SET_BITS-1:0];
	assign e_tag = exe_pc[bp_pkg::PC_W-1:SET_BITS];
	assign e_hit = match_ways(e_set, e_tag);
	assign e_way = way_index(e_hit);
	assign e_ctr = ctr_q[e_set][e_way];
	assign upd   = exe_update.valid && single_hit(e_hit);

	// saturating step toward the outcome
	always_comb begin
		if (exe_update.taken) begin
			e_next = (e_ctr == 2'b11) ? e_ctr : e_ctr + 2'd1;
		end else begin
			e_next = (e_ctr == 2'b00) ? e_ctr : e_ctr - 2'd1;
		end
	end

	////////////////////////////////////////////////
	// table write
	////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < SETS; s++) begin
				fifo_q[s] <= '0;
				for (int w = 0; w < WAYS; w++) begin
					valid_q[s][w] <= 1'b0;
				end
			end
		end else if (alloc) begin
			valid_q[d_set][d_way] <= 1'b1;
			fifo_q[d_set]         <= d_way + WAY_BITS'(1);
		end
	end

	// allocation has priority, a same-cycle update is dropped
	always_ff @(posedge CLK) begin
		if (alloc) begin
			tag_q[d_set][d_way] <= d_tag;
			tgt_q[d_set][d_way] <= id_info.target;
			ctr_q[d_set][d_way] <= alloc_ctr;
		end else if (upd) begin
			ctr_q[e_set][e_way] <= e_next;
		end
	end

	// a tag lives in at most one way of its set
	a_no_multi_hit: assert property (
		@(posedge CLK) disable iff (!nrst)
		$onehot0(f_hit) && $onehot0(d_hit) && $onehot0(e_hit)
	) else $error("tag found in more than one way");

	// a fresh allocation leaves exactly one copy of the tag behind
	a_alloc_unique: assert property (
		@(posedge CLK) disable iff (!nrst)
		alloc |=> $onehot(match_ways($past(d_set), $past(d_tag)))
	) else $error("allocation duplicated or lost a tag");

endmodule

// ==== verilog/branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver (
	input  bp_pkg::stage_t     exe_stage,
	input  bp_pkg::exe_flags_t exe_flags,
	output bp_pkg::redirect_t  redirect,
	output bp_pkg::update_t    exe_update
);

	logic         is_branch;
	logic         taken;
	bp_pkg::btype_t bt;

	assign bt = exe_flags.btype;

	// jumps come with btype zero and skip resolution
	// so a predicted-taken jump is never corrected
	assign is_branch = exe_stage.valid && (bt != '0);

	////////////////////////////////////////////////
	// branch condition
	////////////////////////////////////////////////

	// z from the compare, less is signed or unsigned per kind
	always_comb begin
		taken = 1'b0;
		if (bt[bp_pkg::BT_BEQ] && exe_flags.z) begin
			taken = 1'b1;
		end
		if (bt[bp_pkg::BT_BNE] && !exe_flags.z) begin
			taken = 1'b1;
		end
		if (bt[bp_pkg::BT_BLT] && exe_flags.less) begin
			taken = 1'b1;
		end
		if (bt[bp_pkg::BT_BGE] && !exe_flags.less) begin
			taken = 1'b1;
		end
		if (bt[bp_pkg::BT_BLTU] && exe_flags.less) begin
			taken = 1'b1;
		end
		if (bt[bp_pkg::BT_BGEU] && !exe_flags.less) begin
			taken = 1'b1;
		end
	end

	////////////////////////////////////////////////
	// mispredict and redirect
	////////////////////////////////////////////////

	assign redirect.valid = is_branch && (taken != exe_stage.pred_taken);
	// taken goes to the carried target, not taken falls through
	assign redirect.pc    = taken ? exe_stage.target : exe_stage.pc + bp_pkg::pc_t'(1);

	// counter training for every resolved branch
	assign exe_update.valid = is_branch;
	assign exe_update.taken = taken;

endmodule

// ==== verilog/pc_select.sv ====
`timescale 1ns/1ps

module pc_select (
	input  logic              CLK,
	input  logic              nrst,
	input  bp_pkg::redirect_t redirect,
	input  logic              pred_taken,
	input  bp_pkg::pc_t       pred_target,
	output bp_pkg::pc_t       fetch_pc
);

	// program counter and its next value
	bp_pkg::pc_t pc_q;
	bp_pkg::pc_t pc_next;

	////////////////////////////////////////////////
	// next fetch address
	////////////////////////////////////////////////

	// execute correction beats the fetch prediction
	always_comb begin
		if (redirect.valid) begin
			pc_next = redirect.pc;
		end else if (pred_taken) begin
			// predicted taken, follow the stored target
			pc_next = pred_target;
		end else begin
			// sequential word
			pc_next = pc_q + bp_pkg::pc_t'(1);
		end
	end

	////////////////////////////////////////////////
	// pc register
	////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			pc_q <= '0;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign fetch_pc = pc_q;

	// fetch restarts at word 0 for as long as reset is held
	a_pc_reset: assert property (
		@(posedge CLK) !nrst |=> (fetch_pc == '0)
	) else $error("fetch_pc not zero after reset edge");

endmodule

// ==== verilog/stage_pipe.sv ====
`timescale 1ns/1ps

module stage_pipe (
	input  logic           CLK,
	input  logic           nrst,
	input  bp_pkg::pc_t    fetch_pc,
	input  logic           fetch_taken,
	input  bp_pkg::pc_t    fetch_target,
	input  logic           flush,
	input  bp_pkg::pc_t    id_target,
	output bp_pkg::stage_t id_stage,
	output bp_pkg::stage_t exe_stage
);

	bp_pkg::stage_t id_q;
	bp_pkg::stage_t exe_q;

	////////////////////////////////////////////////
	// fetch to decode
	////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		id_q.pc         <= fetch_pc;
		id_q.pred_taken <= fetch_taken;
		id_q.target     <= fetch_target;
		// fetch issues every cycle, only reset or flush empties the slot
		if (!nrst || flush) begin
			id_q.valid <= 1'b0;
		end else begin
			id_q.valid <= 1'b1;
		end
	end

	////////////////////////////////////////////////
	// decode to execute
	////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		exe_q.pc         <= id_q.pc;
		exe_q.pred_taken <= id_q.pred_taken;
		// table target only known good on a predicted-taken hit
		// otherwise take the decoded target
		exe_q.target     <= id_q.pred_taken ? id_q.target : id_target;
		if (!nrst || flush) begin
			exe_q.valid <= 1'b0;
		end else begin
			exe_q.valid <= id_q.valid;
		end
	end

	assign id_stage  = id_q;
	assign exe_stage = exe_q;

	// wrong-path work never reaches execute
	a_flush_kills: assert property (
		@(posedge CLK) disable iff (!nrst) flush |=> !exe_stage.valid
	) else $error("execute slot valid after flush");

endmodule
